/* hw/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rx_valid_i,
    input  lane_pkg::spi_word_u    rx_word_i,
    input  lane_pkg::steer_cfg_t   cfg_i,
    output logic                   beat_valid_o,
    output lane_pkg::pix_beat_t    beat_o,
    input  logic                   score_valid_i,
    input  lane_pkg::score_t       score_i,
    output logic                   tx_start_o,
    output lane_pkg::motor_frame_t tx_frame_o,
    input  logic                   tx_done_i,
    output logic [3:0]             status_led_o
);

    import lane_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    score_t     score_q;
    score_t     thr;
    motor_cmd_e cmd;
    logic       take_pix;

    // pixels outside idle/receiving are dropped
    assign take_pix = rx_valid_i && !rx_word_i.pix.is_cfg &&
                      (state_q == S_IDLE || state_q == S_RECEIVING);

    assign thr = {16'd0, cfg_i.threshold};

    // dead band around zero
    always_comb begin
        if (score_q > thr) begin
            cmd = CMD_RIGHT;
        end else if (score_q < -thr) begin
            cmd = CMD_LEFT;
        end else begin
            cmd = CMD_STOP;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:       if (take_pix) state_d = S_RECEIVING;
            S_RECEIVING:  if (score_valid_i) state_d = S_PROCESSING;
            S_PROCESSING: state_d = S_SENDING;
            S_SENDING:    if (tx_done_i) state_d = S_DONE;
            S_DONE:       state_d = S_IDLE;
            default:      state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= S_IDLE;
            beat_valid_o <= 1'b0;
            tx_start_o   <= 1'b0;
        end else begin
            state_q      <= state_d;
            beat_valid_o <= take_pix;
            // one pulse on entry to sending
            tx_start_o   <= (state_q == S_PROCESSING);
        end
    end

    always_ff @(posedge clk) begin
        if (take_pix) begin
            beat_o.first <= (state_q == S_IDLE);
            beat_o.pixel <= rx_word_i.pix.pixel;
        end
        if (state_q == S_RECEIVING && score_valid_i) begin
            score_q <= score_i;
        end
        if (state_q == S_PROCESSING) begin
            tx_frame_o.header <= cfg_i.header;
            tx_frame_o.pad    <= 5'd0;
            tx_frame_o.cmd    <= cmd;
        end
    end

    always_comb begin
        case (state_q)
            S_IDLE:       status_led_o = 4'b0001;
            S_RECEIVING:  status_led_o = 4'b0010;
            S_PROCESSING: status_led_o = 4'b0100;
            S_SENDING:    status_led_o = 4'b1000;
            S_DONE:       status_led_o = 4'b1111;
            default:      status_led_o = 4'b0001;
        endcase
    end

endmodule

/* hw/lane_pkg.sv */
package lane_pkg;

    // host word, pixel view
    typedef struct packed {
        logic       is_cfg;
        logic [6:0] rsvd;
        logic [7:0] pixel;
    } pix_word_t;

    // host word, register write view
    typedef struct packed {
        logic       is_cfg;
        logic [6:0] reg_addr;
        logic [7:0] reg_data;
    } cfg_word_t;

    // top bit picks the view
    typedef union packed {
        pix_word_t pix;
        cfg_word_t cfg;
    } spi_word_u;

    typedef struct packed {
        logic       first;
        logic [7:0] pixel;
    } pix_beat_t;

    typedef struct packed {
        logic [7:0] threshold;
        logic [7:0] header;
    } steer_cfg_t;

    typedef enum logic [2:0] {
        CMD_STOP  = 3'b000,
        CMD_RIGHT = 3'b001,
        CMD_LEFT  = 3'b010
    } motor_cmd_e;

    typedef struct packed {
        logic [7:0] header;
        logic [4:0] pad;
        motor_cmd_e cmd;
    } motor_frame_t;

    typedef logic signed [23:0] score_t;

    typedef enum logic [2:0] {
        S_IDLE       = 3'd0,
        S_RECEIVING  = 3'd1,
        S_PROCESSING = 3'd2,
        S_SENDING    = 3'd3,
        S_DONE       = 3'd4
    } seq_state_e;

    localparam logic [6:0] CFG_ADDR_THRESHOLD  = 7'd0;
    localparam logic [6:0] CFG_ADDR_HEADER     = 7'd1;
    localparam logic [7:0] CFG_RESET_THRESHOLD = 8'd0;
    localparam logic [7:0] CFG_RESET_HEADER    = 8'hA5;

endpackage

/* hw/lane_score_engine.sv */
`timescale 1ns/1ps

module lane_score_engine #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                beat_valid_i,
    input  lane_pkg::pix_beat_t beat_i,
    output logic                score_valid_o,
    output lane_pkg::score_t    score_o
);

    import lane_pkg::*;

    localparam int PIX_N = IMG_W * IMG_H;
    localparam int COL_W = (IMG_W > 1) ? $clog2(IMG_W) : 1;
    localparam int CNT_W = $clog2(PIX_N + 1);

    logic [COL_W-1:0] col_q;
    logic [COL_W-1:0] col;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt;
    score_t           sum_q;
    score_t           sum_base;
    score_t           pix_ext;
    score_t           sum_d;

    // first beat restarts the image
    assign col      = beat_i.first ? '0 : col_q;
    assign cnt      = beat_i.first ? '0 : cnt_q;
    assign sum_base = beat_i.first ? '0 : sum_q;
    assign pix_ext  = {16'd0, beat_i.pixel};

    // left half columns pull negative
    assign sum_d = (col < COL_W'(IMG_W / 2)) ? sum_base - pix_ext : sum_base + pix_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q         <= '0;
            cnt_q         <= '0;
            score_valid_o <= 1'b0;
        end else begin
            score_valid_o <= beat_valid_i && (cnt == CNT_W'(PIX_N - 1));
            if (beat_valid_i) begin
                col_q <= (col == COL_W'(IMG_W - 1)) ? '0 : col + 1'b1;
                cnt_q <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            sum_q   <= sum_d;
            score_o <= sum_d;
        end
    end

endmodule

/* hw/lane_steer_top.sv */
`timescale 1ns/1ps

module lane_steer_top #(
    parameter int IMG_W    = 8,
    parameter int IMG_H    = 4,
    parameter int SCLK_DIV = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_slave_sclk_i,
    input  logic       spi_slave_ss_i,
    input  logic       spi_slave_mosi_i,
    output logic       spi_master_sclk_o,
    output logic       spi_master_mosi_o,
    output logic       spi_master_ss_o,
    output logic [3:0] status_led_o
);

    import lane_pkg::*;

    logic         rx_valid;
    spi_word_u    rx_word;
    steer_cfg_t   cfg;
    logic         beat_valid;
    pix_beat_t    beat;
    logic         score_valid;
    score_t       score;
    logic         tx_start;
    motor_frame_t tx_frame;
    logic         tx_done;

    spi_word_rx u_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .spi_sclk_i (spi_slave_sclk_i),
        .spi_ss_i   (spi_slave_ss_i),
        .spi_mosi_i (spi_slave_mosi_i),
        .rx_valid_o (rx_valid),
        .rx_word_o  (rx_word)
    );

    steer_cfg_regs u_cfg (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_valid_i (rx_valid),
        .rx_word_i  (rx_word),
        .cfg_o      (cfg)
    );

    frame_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_valid_i    (rx_valid),
        .rx_word_i     (rx_word),
        .cfg_i         (cfg),
        .beat_valid_o  (beat_valid),
        .beat_o        (beat),
        .score_valid_i (score_valid),
        .score_i       (score),
        .tx_start_o    (tx_start),
        .tx_frame_o    (tx_frame),
        .tx_done_i     (tx_done),
        .status_led_o  (status_led_o)
    );

    lane_score_engine #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .beat_valid_i  (beat_valid),
        .beat_i        (beat),
        .score_valid_o (score_valid),
        .score_o       (score)
    );

    motor_cmd_tx #(
        .SCLK_DIV (SCLK_DIV)
    ) u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_start_i (tx_start),
        .tx_frame_i (tx_frame),
        .tx_done_o  (tx_done),
        .spi_sclk_o (spi_master_sclk_o),
        .spi_mosi_o (spi_master_mosi_o),
        .spi_ss_o   (spi_master_ss_o)
    );

endmodule

/* hw/motor_cmd_tx.sv */
`timescale 1ns/1ps

module motor_cmd_tx #(
    parameter int SCLK_DIV = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tx_start_i,
    input  lane_pkg::motor_frame_t tx_frame_i,
    output logic                   tx_done_o,
    output logic                   spi_sclk_o,
    output logic                   spi_mosi_o,
    output logic                   spi_ss_o
);

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

    logic             busy_q;
    logic             sclk_q;
    logic             ss_q;
    logic             half_tick;
    logic [DIV_W-1:0] div_q;
    logic [3:0]       bit_q;
    logic [15:0]      shift_q;

    // end of one sclk half period
    assign half_tick = busy_q && !ss_q && (div_q == DIV_W'(SCLK_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            sclk_q    <= 1'b0;
            ss_q      <= 1'b1;
            div_q     <= '0;
            bit_q     <= 4'd0;
            shift_q   <= 16'd0;
            tx_done_o <= 1'b0;
        end else begin
            tx_done_o <= 1'b0;
            if (!busy_q) begin
                // first bit already on mosi before the first rise
                if (tx_start_i) begin
                    busy_q  <= 1'b1;
                    ss_q    <= 1'b0;
                    div_q   <= '0;
                    bit_q   <= 4'd0;
                    shift_q <= tx_frame_i;
                end
            end else if (ss_q) begin
                // ss went high last cycle
                busy_q    <= 1'b0;
                tx_done_o <= 1'b1;
            end else if (half_tick) begin
                div_q  <= '0;
                sclk_q <= ~sclk_q;
                // falling edge shifts the next bit out
                if (sclk_q) begin
                    if (bit_q == 4'd15) begin
                        ss_q <= 1'b1;
                    end else begin
                        shift_q <= {shift_q[14:0], 1'b0};
                        bit_q   <= bit_q + 4'd1;
                    end
                end
            end else begin
                div_q <= div_q + 1'b1;
            end
        end
    end

    assign spi_sclk_o = sclk_q;
    assign spi_ss_o   = ss_q;
    assign spi_mosi_o = shift_q[15];

endmodule

/* hw/spi_word_rx.sv */
`timescale 1ns/1ps

module spi_word_rx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                spi_sclk_i,
    input  logic                spi_ss_i,
    input  logic                spi_mosi_i,
    output logic                rx_valid_o,
    output lane_pkg::spi_word_u rx_word_o
);

    logic [1:0]  sclk_sync;
    logic [1:0]  ss_sync;
    logic [1:0]  mosi_sync;
    logic        sclk_prev;
    logic        sclk_rise;
    logic        bit_take;
    logic        word_done;
    logic [3:0]  bit_cnt;
    logic [14:0] shift_q;

    // two-flop synchronizers, ss idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= 2'b00;
            ss_sync   <= 2'b11;
            mosi_sync <= 2'b00;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk_i};
            ss_sync   <= {ss_sync[0], spi_ss_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    // mode 0, sample on rising sclk while selected
    assign bit_take  = sclk_rise & ~ss_sync[1];
    assign word_done = bit_take && (bit_cnt == 4'd15);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= 4'd0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= word_done;
            // deselect drops any partial word
            if (ss_sync[1]) begin
                bit_cnt <= 4'd0;
            end else if (bit_take) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // msb first
    always_ff @(posedge clk) begin
        if (bit_take) begin
            shift_q <= {shift_q[13:0], mosi_sync[1]};
        end
        if (word_done) begin
            rx_word_o <= {shift_q, mosi_sync[1]};
        end
    end

endmodule

/* hw/steer_cfg_regs.sv */
`timescale 1ns/1ps

module steer_cfg_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rx_valid_i,
    input  lane_pkg::spi_word_u  rx_word_i,
    output lane_pkg::steer_cfg_t cfg_o
);

    import lane_pkg::*;

    logic cfg_wr;

    // register writes are accepted in any sequencer state
    assign cfg_wr = rx_valid_i && rx_word_i.cfg.is_cfg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_o.threshold <= CFG_RESET_THRESHOLD;
            cfg_o.header    <= CFG_RESET_HEADER;
        end else if (cfg_wr) begin
            case (rx_word_i.cfg.reg_addr)
                CFG_ADDR_THRESHOLD: begin
                    cfg_o.threshold <= rx_word_i.cfg.reg_data;
                end
                CFG_ADDR_HEADER: begin
                    cfg_o.header <= rx_word_i.cfg.reg_data;
                end
                default: begin
                    // unknown address, nothing to update
                end
            endcase
        end
    end

endmodule

/* lane_steer_top.f */
hw/lane_pkg.sv
hw/spi_word_rx.sv
hw/steer_cfg_regs.sv
hw/lane_score_engine.sv
hw/frame_sequencer.sv
hw/motor_cmd_tx.sv
hw/lane_steer_top.sv
tests/lane_steer_props.sv
tests/lane_steer_tb.sv

/* tests/lane_steer_props.sv */
`timescale 1ns/1ps

module lane_steer_props (
    input logic       clk,
    input logic       rst_n,
    input logic [3:0] status_led_i,
    input logic       master_sclk_i,
    input logic       master_ss_i,
    input logic       rx_valid_i
);

    // one state led, or all of them in done
    led_code_check : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(status_led_i) || (status_led_i == 4'b1111))
        else $error("status leds show an illegal pattern");

    // master sclk idles low whenever the slave is deselected
    sclk_idle_check : assert property (@(posedge clk) disable iff (!rst_n)
        master_ss_i |-> !master_sclk_i)
        else $error("master sclk high while ss is high");

    rx_strobe_check : assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid_i |=> !rx_valid_i)
        else $error("rx_valid held for two cycles");

endmodule

bind lane_steer_top lane_steer_props props_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .status_led_i  (status_led_o),
    .master_sclk_i (spi_master_sclk_o),
    .master_ss_i   (spi_master_ss_o),
    .rx_valid_i    (rx_valid)
);

/* tests/lane_steer_tb.sv */
`timescale 1ns/1ps

module lane_steer_tb;

    localparam int IMG_W          = 8;
    localparam int IMG_H          = 4;
    localparam int IMG_N          = IMG_W * IMG_H;
    localparam int HALF_CLKS      = 4;
    localparam int TIMEOUT_CYCLES = 60000;

    logic       clk;
    logic       rst_n;
    logic       sclk;
    logic       ss;
    logic       mosi;
    logic       m_sclk;
    logic       m_mosi;
    logic       m_ss;
    logic [3:0] led;
    logic [7:0] img [IMG_N];
    logic [7:0] thr_model;
    logic [7:0] hdr_model;
    logic [15:0] frame;
    int         cycles;

    lane_steer_top dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .spi_slave_sclk_i  (sclk),
        .spi_slave_ss_i    (ss),
        .spi_slave_mosi_i  (mosi),
        .spi_master_sclk_o (m_sclk),
        .spi_master_mosi_o (m_mosi),
        .spi_master_ss_o   (m_ss),
        .status_led_o      (led)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d clock cycles", cycles);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check_eq(input string test_name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Fail %s: %s expected %0h actual %0h", test_name, what, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input string test_name, input logic cond, input string msg);
        assert (cond) else begin
            $display("Error in %s: %s", test_name, msg);
            $display("Simulation FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // spi mode 0 host, msb first
    task automatic send_word(input logic [15:0] w);
        ss = 1'b0;
        for (int b = 15; b >= 0; b--) begin
            mosi = w[b];
            repeat (HALF_CLKS) @(negedge clk);
            sclk = 1'b1;
            repeat (HALF_CLKS) @(negedge clk);
            sclk = 1'b0;
        end
        ss = 1'b1;
        repeat (HALF_CLKS) @(negedge clk);
    endtask

    task automatic send_pixel(input logic [7:0] p);
        send_word({1'b0, 7'd0, p});
    endtask

    task automatic send_cfg(input logic [6:0] addr, input logic [7:0] data);
        send_word({1'b1, addr, data});
    endtask

    task automatic send_image();
        for (int i = 0; i < IMG_N; i++) begin
            send_pixel(img[i]);
        end
    endtask

    // sample master mosi on each sclk rise seen at the falling clk edge
    task automatic capture_frame(output logic [15:0] f);
        int   nbits;
        logic prev;
        f     = 16'd0;
        nbits = 0;
        prev  = 1'b0;
        while (m_ss) @(negedge clk);
        while (nbits < 16) begin
            @(negedge clk);
            if (m_sclk && !prev) begin
                f     = {f[14:0], m_mosi};
                nbits = nbits + 1;
            end
            prev = m_sclk;
        end
    endtask

    function automatic int score_of();
        int s;
        s = 0;
        for (int i = 0; i < IMG_N; i++) begin
            if ((i % IMG_W) < (IMG_W / 2)) s = s - int'(img[i]);
            else s = s + int'(img[i]);
        end
        return s;
    endfunction

    function automatic logic [2:0] expected_cmd(input int s, input int thr);
        if (s > thr) return 3'b001;
        else if (s < -thr) return 3'b010;
        else return 3'b000;
    endfunction

    task automatic fill_random();
        for (int i = 0; i < IMG_N; i++) begin
            img[i] = 8'($urandom_range(255, 0));
        end
    endtask

    // done shows for one clk, then back to idle
    task automatic finish_frame(input string test_name);
        int waited;
        waited = 0;
        while (led !== 4'b1111 && waited < 16) begin
            @(negedge clk);
            waited = waited + 1;
        end
        check_true(test_name, led === 4'b1111, "status leds never showed the done pattern");
        @(negedge clk);
        check_eq(test_name, "status leds", 32'h1, led);
    endtask

    task automatic check_frame(input string test_name);
        check_eq(test_name, "motor frame",
                 {hdr_model, 5'd0, expected_cmd(score_of(), thr_model)}, frame);
        finish_frame(test_name);
    endtask

    task automatic run_frame(input string test_name);
        fork
            send_image();
            capture_frame(frame);
        join
        check_frame(test_name);
    endtask

    task automatic test_reset();
        check_eq("test_reset", "status leds", 32'h1, led);
        check_eq("test_reset", "master ss", 32'h1, m_ss);
        check_eq("test_reset", "master sclk", 32'h0, m_sclk);
    endtask

    task automatic test_steer_right();
        for (int i = 0; i < IMG_N; i++) begin
            img[i] = ((i % IMG_W) < (IMG_W / 2)) ? 8'd12 : 8'd230;
        end
        run_frame("test_steer_right");
    endtask

    task automatic test_steer_left();
        for (int i = 0; i < IMG_N; i++) begin
            img[i] = ((i % IMG_W) < (IMG_W / 2)) ? 8'd230 : 8'd12;
        end
        run_frame("test_steer_left");
    endtask

    task automatic test_config_deadband();
        // keep the score inside the dead band
        do begin
            fill_random();
        end while (score_of() > 200 || score_of() < -200);
        fork
            begin
                for (int i = 0; i < IMG_N; i++) begin
                    if (i == 5) send_cfg(7'd0, 8'd200);
                    if (i == 20) send_cfg(7'd1, 8'h3C);
                    send_pixel(img[i]);
                end
            end
            capture_frame(frame);
        join
        thr_model = 8'd200;
        hdr_model = 8'h3C;
        check_frame("test_config_deadband");
    endtask

    task automatic test_random_frames();
        repeat (3) begin
            fill_random();
            run_frame("test_random_frames");
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        sclk      = 1'b0;
        ss        = 1'b1;
        mosi      = 1'b0;
        cycles    = 0;
        thr_model = 8'd0;
        hdr_model = 8'hA5;
        void'($urandom(48));
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_steer_right();
        test_steer_left();
        test_config_deadband();
        test_random_frames();
        $display("Simulation PASSED");
        $finish;
    end

endmodule
